// ==== verif/aluApb_assert.sv ====
`timescale 1ns/1ps

// APB protocol and result capture checks on the register bank
module aluApbAssert
(
    input logic           clk,
    input logic           arstN,
    input aluPkg::apbReqT apbReq,
    input aluPkg::apbRspT apbRsp,
    input logic           start,
    input logic [31:0]    resultReg
);

    int failCount = 0;    // Assertion failures so far

    // Zero wait states, always ready
    readyHigh : assert property (@(posedge clk) disable iff (!arstN) apbRsp.pready)
    else
    begin
        failCount++;
        $error("pready went low");
    end

    slvErrInAccess : assert property (@(posedge clk) disable iff (!arstN)
        apbRsp.pslverr |-> (apbReq.psel && apbReq.penable))
    else
    begin
        failCount++;
        $error("pslverr raised outside an access phase");
    end

    // Capture happens on the edge where start is high
    resultAfterStart : assert property (@(posedge clk) disable iff (!arstN)
        (resultReg != $past(resultReg)) |-> $past(start))
    else
    begin
        failCount++;
        $error("Result register changed without a start pulse");
    end

    startPulse : assert property (@(posedge clk) disable iff (!arstN) start |=> !start)
    else
    begin
        failCount++;
        $error("start held high for more than one cycle");
    end

endmodule

bind aluRegs aluApbAssert i_apbAssert
(
    .clk       (clk),
    .arstN     (arstN),
    .apbReq    (apbReq),
    .apbRsp    (apbRsp),
    .start     (start),
    .resultReg (resultReg)
);

// ==== verif/aluGolden.txt ====
# opA opB funct result status, all hex; status bits 4..0 are illegal carry overflow negative zero
# Lines run in order, MOVN and MOVZ misses keep the previous result
F0F0F0F0 FF00FF00 24 F000F000 02   # AND
0000FFFF FFFF0000 25 FFFFFFFF 02   # OR
12345678 12345678 26 00000000 01   # XOR
0F0F0F0F 30303030 27 C0C0C0C0 02   # NOR
FFFFFFFF 00000001 21 00000000 09   # ADDU wraps with carry
00000005 00000003 21 00000008 00   # ADDU
00000003 00000005 23 FFFFFFFE 0A   # SUBU borrow
7FFFFFFF 00000001 20 80000000 06   # ADD overflow
80000000 00000001 22 7FFFFFFF 04   # SUB overflow
00000000 80000001 00 00000002 00   # SLL
00000000 80000001 02 40000000 00   # SRL
00000000 80000001 03 C0000000 02   # SRA
00000024 00000001 04 00000010 00   # SLLV, only low five bits count
0000001F 80000000 06 00000001 00   # SRLV by 31
0000001F 80000000 07 FFFFFFFF 02   # SRAV by 31
FFFFFFFF 00000001 2A 00000001 00   # SLT
FFFFFFFF 00000001 2B 00000000 01   # SLTU
FFFFFFFF 00000000 1C 00000020 00   # CLO all ones
7FFFFFFF 00000000 1C 00000000 01   # CLO none
00010000 00000000 1D 0000000F 00   # CLZ
00000000 00000000 1D 00000020 00   # CLZ all zeros
89ABCDEF 00000001 0B 89ABCDEF 02   # MOVN taken
11111111 00000000 0B 89ABCDEF 02   # MOVN kept
00000000 00000000 0A 00000000 01   # MOVZ taken
22222222 00000005 0A 00000000 01   # MOVZ kept
00000001 00000002 3F 00000000 10   # Illegal code

// ==== verif/aluTb.sv ====
`timescale 1ns/1ps

// APB testbench for the ALU peripheral, operations come from the golden file
module aluTb;

    import aluPkg::*;

    localparam int         READY_TIMEOUT = 20;       // Cycles allowed for pready
    localparam logic [7:0] REG_UNMAPPED  = 8'h14;    // First offset past the map

    logic   clk;
    logic   arstN;
    apbReqT apbReq;
    apbRspT apbRsp;

    aluApbTop i_dut
    (
        .clk    (clk),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #50 clk = ~clk;    // 100 ns period

    // Any bound checker failure ends the run
    always @(i_dut.i_regs.i_apbAssert.failCount)
    begin
        if (i_dut.i_regs.i_apbAssert.failCount != 0)
        begin
            $display("Error: APB assertion failed in the register bank");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic stopRun(input string reason);
    begin
        $display("Error: %s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    begin
        assert (actual === expected)
        else
        begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
    begin
        int waitCycles;
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1 apbReq.penable = 1'b1;    // Access phase
        waitCycles = 0;
        @(negedge clk);
        while (!apbRsp.pready)
        begin
            waitCycles++;
            if (waitCycles >= READY_TIMEOUT)
                stopRun($sformatf("No pready within %0d cycles at address 0x%02h",
                                  waitCycles, addr));
            @(negedge clk);
        end
        rdata = apbRsp.prdata;    // Mid-cycle, settled
        err   = apbRsp.pslverr;
        @(posedge clk);
        #1 apbReq = '0;
        repeat ($urandom % 4)    // 0 to 3 idle cycles
        begin
            @(posedge clk);
            #1;
        end
    end
    endtask

    task automatic writeCheck(input logic [7:0] addr, input logic [31:0] data,
                              input logic expErr);
    begin
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, addr, data, rdata, err);
        checkValue("pslverr", 32'(expErr), 32'(err));
    end
    endtask

    task automatic readCheck(input logic [7:0] addr, input string name,
                             input logic [31:0] expected);
    begin
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b0, addr, 32'd0, rdata, err);
        checkValue("pslverr", 32'd0, 32'(err));
        checkValue(name, expected, rdata);
    end
    endtask

    initial
    begin
        int          fd;
        int          opCount;
        string       line;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] funct;
        logic [31:0] expResult;
        logic [31:0] expStatus;
        logic [31:0] rdata;
        logic        err;

        void'($urandom(32'hce90));
        clk     = 1'b0;
        arstN   = 1'b0;
        apbReq  = '0;
        opCount = 0;
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;

        readCheck(REG_OPA, "opA", 32'd0);    // Reset values
        readCheck(REG_OPB, "opB", 32'd0);
        readCheck(REG_RESULT, "result", 32'd0);
        readCheck(REG_STATUS, "status", 32'd0);

        fd = $fopen("verif/aluGolden.txt", "r");
        if (fd == 0)
            stopRun("Cannot open verif/aluGolden.txt");
        while ($fgets(line, fd) != 0)
        begin
            // Comment lines give no fields
            if ($sscanf(line, "%h %h %h %h %h", opA, opB, funct, expResult, expStatus) == 5)
            begin
                writeCheck(REG_OPA, opA, 1'b0);
                writeCheck(REG_OPB, opB, 1'b0);
                writeCheck(REG_FUNCT, funct, 1'b0);    // Starts the operation
                readCheck(REG_RESULT, "result", expResult);
                readCheck(REG_STATUS, "status", expStatus);
                opCount++;
            end
        end
        $fclose(fd);
        if (opCount == 0)
            stopRun("Golden file holds no operations");

        // Bad accesses flag pslverr and leave the last operation's state alone
        writeCheck(REG_RESULT, 32'hDEADBEEF, 1'b1);
        writeCheck(REG_STATUS, 32'h0000001F, 1'b1);
        writeCheck(REG_UNMAPPED, 32'h12345678, 1'b1);
        apbTransfer(1'b0, REG_UNMAPPED, 32'd0, rdata, err);
        checkValue("pslverr", 32'd1, 32'(err));
        readCheck(REG_RESULT, "result", expResult);
        readCheck(REG_STATUS, "status", expStatus);
        readCheck(REG_OPA, "opA", opA);
        readCheck(REG_OPB, "opB", opB);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

// Combinational MIPS integer ALU
module alu
(
    input  aluPkg::aluReqT req,
    output aluPkg::aluRspT rsp
);

    import aluPkg::*;

    logic [32:0] sumU;       // Unsigned add with carry out
    logic [32:0] diffU;      // Unsigned subtract, bit 32 is borrow
    logic [32:0] diffS;      // Sign-extended subtract for SUB overflow
    logic        addOvf;
    logic        subOvf;

    logic [4:0]  shAmount;
    logic        shRight;
    logic        shArith;
    logic [31:0] shResult;

    logic [5:0]  bitCount;

    assign sumU  = {1'b0, req.opA} + {1'b0, req.opB};
    assign diffU = {1'b0, req.opA} - {1'b0, req.opB};
    assign diffS = {req.opA[31], req.opA} - {req.opB[31], req.opB};

    // Same-sign operands giving a differently signed sum
    assign addOvf = (req.opA[31] == req.opB[31]) && (sumU[31] != req.opA[31]);
    assign subOvf = diffS[32] != diffS[31];    // Top two bits disagree

    // Shift controls from the function code
    always_comb
    begin
        shRight  = 1'b0;
        shArith  = 1'b0;
        shAmount = 5'd1;    // Fixed forms, no shamt field
        case (req.funct)
            FN_SRL:  shRight = 1'b1;
            FN_SRA:
            begin
                shRight = 1'b1;
                shArith = 1'b1;
            end
            FN_SLLV: shAmount = req.opA[4:0];
            FN_SRLV:
            begin
                shRight  = 1'b1;
                shAmount = req.opA[4:0];
            end
            FN_SRAV:
            begin
                shRight  = 1'b1;
                shArith  = 1'b1;
                shAmount = req.opA[4:0];
            end
            default: ;
        endcase
    end

    shifter i_shifter
    (
        .value    (req.opB),
        .amount   (shAmount),
        .dirRight (shRight),
        .arith    (shArith),
        .shifted  (shResult)
    );

    bitCounter i_bitCounter
    (
        .value     (req.opA),
        .countOnes (req.funct == FN_CLO),
        .count     (bitCount)
    );

    always_comb
    begin
        rsp             = '0;    // Zero and negative stay 0, derived in aluRegs
        rsp.writeResult = 1'b1;
        case (req.funct)
            FN_MOVN:
            begin
                rsp.result      = req.opA;
                rsp.writeResult = req.opB != 32'd0;
            end
            FN_MOVZ:
            begin
                rsp.result      = req.opA;
                rsp.writeResult = req.opB == 32'd0;
            end
            FN_AND:  rsp.result = req.opA & req.opB;
            FN_OR:   rsp.result = req.opA | req.opB;
            FN_XOR:  rsp.result = req.opA ^ req.opB;
            FN_NOR:  rsp.result = ~(req.opA | req.opB);
            FN_ADDU: {rsp.flags.carry, rsp.result} = sumU;
            FN_SUBU: {rsp.flags.carry, rsp.result} = diffU;    // Borrow out
            FN_ADD:
            begin
                rsp.result         = sumU[31:0];
                rsp.flags.overflow = addOvf;    // No trap taken
            end
            FN_SUB:
            begin
                rsp.result         = diffS[31:0];
                rsp.flags.overflow = subOvf;
            end
            FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: rsp.result = shResult;
            FN_SLT:  rsp.result = {31'd0, $signed(req.opA) < $signed(req.opB)};
            FN_SLTU: rsp.result = {31'd0, req.opA < req.opB};
            FN_CLO, FN_CLZ: rsp.result = {26'd0, bitCount};
            default:
            begin
                rsp.writeResult   = 1'b0;    // Keep old result
                rsp.flags.illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== verilog/aluApbTop.sv ====
`timescale 1ns/1ps

// APB ALU peripheral, register bank plus ALU
module aluApbTop
(
    input  logic           clk,
    input  logic           arstN,
    input  aluPkg::apbReqT apbReq,
    output aluPkg::apbRspT apbRsp
);

    import aluPkg::*;

    aluReqT aluReq;    // Registered operands and code
    aluRspT aluRsp;    // Combinational result and flags

    aluRegs i_regs
    (
        .clk    (clk),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .aluReq (aluReq),
        .aluRsp (aluRsp)
    );

    alu i_alu
    (
        .req (aluReq),
        .rsp (aluRsp)
    );

endmodule

// ==== verilog/aluPkg.sv ====
package aluPkg;

    // MIPS function codes handled by the ALU
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_CLO  = 6'b011100,
        FN_CLZ  = 6'b011101,
        FN_ADD  = 6'b100000,    // Signed, reports overflow
        FN_ADDU = 6'b100001,    // Unsigned, reports carry
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,    // Carry means borrow here
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } functT;

    // APB register map, byte offsets
    localparam logic [7:0] REG_OPA    = 8'h00;
    localparam logic [7:0] REG_OPB    = 8'h04;
    localparam logic [7:0] REG_FUNCT  = 8'h08;    // Write starts an operation
    localparam logic [7:0] REG_RESULT = 8'h0C;    // Read only
    localparam logic [7:0] REG_STATUS = 8'h10;    // Read only, flags in bits 4..0

    // Status word, bit 4 down to bit 0
    typedef struct packed {
        logic illegal;
        logic carry;
        logic overflow;
        logic negative;
        logic zero;
    } flagsT;

    typedef struct packed {
        logic [31:0] opA;
        logic [31:0] opB;
        functT       funct;
    } aluReqT;

    typedef struct packed {
        logic [31:0] result;
        logic        writeResult;    // Low keeps the held result
        flagsT       flags;
    } aluRspT;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

endpackage

// ==== verilog/aluRegs.sv ====
`timescale 1ns/1ps

// APB register bank around the ALU, zero wait states
module aluRegs
(
    input  logic           clk,
    input  logic           arstN,
    input  aluPkg::apbReqT apbReq,
    output aluPkg::apbRspT apbRsp,
    output aluPkg::aluReqT aluReq,
    input  aluPkg::aluRspT aluRsp
);

    import aluPkg::*;

    logic        access;       // Second APB phase
    logic        wrAccess;
    logic        mapped;       // One of the five offsets
    logic        writable;     // Operand or function register

    logic [31:0] opAReg;
    logic [31:0] opBReg;
    logic [5:0]  functReg;     // Raw code, may be illegal
    logic [31:0] resultReg;
    flagsT       statusReg;
    logic        start;        // One cycle after a REG_FUNCT write

    logic [31:0] nextResult;   // Value the result register will hold
    flagsT       nextStatus;
    logic [31:0] readData;

    assign access   = apbReq.psel & apbReq.penable;
    assign wrAccess = access & apbReq.pwrite;

    assign writable = (apbReq.paddr == REG_OPA) || (apbReq.paddr == REG_OPB) ||
                      (apbReq.paddr == REG_FUNCT);
    assign mapped   = writable || (apbReq.paddr == REG_RESULT) ||
                      (apbReq.paddr == REG_STATUS);

    always_comb
    begin
        case (apbReq.paddr)
            REG_OPA:    readData = opAReg;
            REG_OPB:    readData = opBReg;
            REG_FUNCT:  readData = {26'd0, functReg};
            REG_RESULT: readData = resultReg;
            REG_STATUS: readData = {27'd0, statusReg};
            default:    readData = 32'd0;
        endcase
    end

    assign apbRsp.prdata  = (access && !apbReq.pwrite) ? readData : 32'd0;
    assign apbRsp.pready  = 1'b1;
    // Unmapped address or write to a read-only register
    assign apbRsp.pslverr = access && (!mapped || (apbReq.pwrite && !writable));

    assign aluReq.opA   = opAReg;
    assign aluReq.opB   = opBReg;
    assign aluReq.funct = functT'(functReg);

    // Flags on the value held after capture
    assign nextResult = aluRsp.writeResult ? aluRsp.result : resultReg;
    always_comb
    begin
        nextStatus          = aluRsp.flags;    // illegal, carry, overflow
        nextStatus.negative = nextResult[31];
        nextStatus.zero     = nextResult == 32'd0;
        if (aluRsp.flags.illegal)
        begin
            nextStatus.negative = 1'b0;    // Illegal code clears the rest
            nextStatus.zero     = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            opAReg    <= '0;
            opBReg    <= '0;
            functReg  <= '0;
            resultReg <= '0;
            statusReg <= '0;
            start     <= 1'b0;
        end
        else
        begin
            start <= wrAccess && (apbReq.paddr == REG_FUNCT);
            if (wrAccess && (apbReq.paddr == REG_OPA))
                opAReg <= apbReq.pwdata;
            if (wrAccess && (apbReq.paddr == REG_OPB))
                opBReg <= apbReq.pwdata;
            if (wrAccess && (apbReq.paddr == REG_FUNCT))
                functReg <= apbReq.pwdata[5:0];    // Upper bits ignored
            if (start)    // Operands and code are settled by now
            begin
                resultReg <= nextResult;
                statusReg <= nextStatus;
            end
        end
    end

endmodule

// ==== verilog/bitCounter.sv ====
`timescale 1ns/1ps

// Leading ones or leading zeros count, scanning from the MSB
module bitCounter
(
    input  logic [31:0] value,
    input  logic        countOnes,    // 1 for CLO, 0 for CLZ
    output logic [5:0]  count         // 0 to 32
);

    logic found;    // First differing bit seen

    always_comb
    begin
        count = 6'd32;    // All bits match the polarity
        found = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            // Stop at the first bit that breaks the run
            if (!found && (value[i] != countOnes))
            begin
                count = 6'(31 - i);
                found = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/shifter.sv ====
`timescale 1ns/1ps

// Barrel shifter, left logical, right logical or right arithmetic
module shifter
(
    input  logic [31:0] value,
    input  logic [4:0]  amount,      // 1 for fixed forms, opA[4:0] for variable
    input  logic        dirRight,    // 0 shifts left
    input  logic        arith,       // Sign fill on right shifts
    output logic [31:0] shifted
);

    logic fillBit;    // Bit shifted in from the top

    assign fillBit = arith & value[31];

    always_comb
    begin
        if (!dirRight)
        begin
            shifted = value << amount;    // Zeros in from the bottom
        end
        else
        begin
            // 64-bit window keeps the fill bits above the value
            shifted = 32'({{32{fillBit}}, value} >> amount);
        end
    end

endmodule

// ==== vlog.f ====
verilog/aluPkg.sv
verilog/bitCounter.sv
verilog/shifter.sv
verilog/alu.sv
verilog/aluRegs.sv
verilog/aluApbTop.sv
verif/aluApb_assert.sv
verif/aluTb.sv
